//--- cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int DMEM_DEPTH = 16
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              instr_valid,
    input  wire cpu_pkg::word_t    instr,
    output logic                   retire_valid,
    output cpu_pkg::word_t         retire_pc,
    output cpu_pkg::reg_idx_t      retire_dest,
    output logic                   retire_we,
    output cpu_pkg::word_t         retire_data
);
    import cpu_pkg::*;

    // decode outputs.
    logic     d_valid;
    word_t    d_pc;
    word_t    d_rs_data;
    word_t    d_rt_data;
    word_t    d_imm;
    reg_idx_t d_rs;
    reg_idx_t d_rt;
    reg_idx_t d_dest;
    alu_op_e  d_alu_op;
    logic     d_alu_src_imm;
    logic     d_mem_read;
    logic     d_mem_write;
    logic     d_reg_write;

    logic     x_valid;
    word_t    x_pc;
    word_t    x_rs_data;
    word_t    x_rt_data;
    word_t    x_imm;
    reg_idx_t x_rs;
    reg_idx_t x_rt;
    reg_idx_t x_dest;
    alu_op_e  x_alu_op;
    logic     x_alu_src_imm;
    logic     x_mem_read;
    logic     x_mem_write;
    logic     x_reg_write;

    logic     e_valid;
    word_t    e_pc;
    reg_idx_t e_dest;
    logic     e_reg_write;
    word_t    e_result;

    logic     w_we;  // also feeds forwarding in execute.
    reg_idx_t w_addr;
    word_t    w_data;

    instr_decoder u_decoder (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .w_we          (w_we),
        .w_addr        (w_addr),
        .w_data        (w_data),
        .d_valid       (d_valid),
        .d_pc          (d_pc),
        .d_rs_data     (d_rs_data),
        .d_rt_data     (d_rt_data),
        .d_imm         (d_imm),
        .d_rs          (d_rs),
        .d_rt          (d_rt),
        .d_dest        (d_dest),
        .d_alu_op      (d_alu_op),
        .d_alu_src_imm (d_alu_src_imm),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write),
        .d_reg_write   (d_reg_write)
    );

    id_ex_reg u_id_ex (
        .clk           (clk),
        .reset_n       (reset_n),
        .d_valid       (d_valid),
        .d_pc          (d_pc),
        .d_rs_data     (d_rs_data),
        .d_rt_data     (d_rt_data),
        .d_imm         (d_imm),
        .d_rs          (d_rs),
        .d_rt          (d_rt),
        .d_dest        (d_dest),
        .d_alu_op      (d_alu_op),
        .d_alu_src_imm (d_alu_src_imm),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write),
        .d_reg_write   (d_reg_write),
        .x_valid       (x_valid),
        .x_pc          (x_pc),
        .x_rs_data     (x_rs_data),
        .x_rt_data     (x_rt_data),
        .x_imm         (x_imm),
        .x_rs          (x_rs),
        .x_rt          (x_rt),
        .x_dest        (x_dest),
        .x_alu_op      (x_alu_op),
        .x_alu_src_imm (x_alu_src_imm),
        .x_mem_read    (x_mem_read),
        .x_mem_write   (x_mem_write),
        .x_reg_write   (x_reg_write)
    );

    execute_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_execute (
        .clk           (clk),
        .reset_n       (reset_n),
        .x_valid       (x_valid),
        .x_pc          (x_pc),
        .x_rs_data     (x_rs_data),
        .x_rt_data     (x_rt_data),
        .x_imm         (x_imm),
        .x_rs          (x_rs),
        .x_rt          (x_rt),
        .x_dest        (x_dest),
        .x_alu_op      (x_alu_op),
        .x_alu_src_imm (x_alu_src_imm),
        .x_mem_read    (x_mem_read),
        .x_mem_write   (x_mem_write),
        .x_reg_write   (x_reg_write),
        .w_we          (w_we),
        .w_addr        (w_addr),
        .w_data        (w_data),
        .e_valid       (e_valid),
        .e_pc          (e_pc),
        .e_dest        (e_dest),
        .e_reg_write   (e_reg_write),
        .e_result      (e_result)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .reset_n      (reset_n),
        .e_valid      (e_valid),
        .e_pc         (e_pc),
        .e_dest       (e_dest),
        .e_reg_write  (e_reg_write),
        .e_result     (e_result),
        .w_we         (w_we),
        .w_addr       (w_addr),
        .w_data       (w_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_dest  (retire_dest),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 2;
    localparam int NUM_REGS  = 1 << REG_IDX_W;
    localparam int OPCODE_W  = 4;
    localparam int FUNC_W    = 6;
    localparam int IMM_W     = 8;
    localparam int ALU_OP_W  = 3;

    // bit positions inside the instruction word.
    localparam int OPC_LSB = 12;
    localparam int RS_LSB  = 10;
    localparam int RT_LSB  = 8;
    localparam int RD_LSB  = 6;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [OPCODE_W-1:0] {
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_rtype = 4'd15
    } opcode_e;

    // low field of an r-type word.
    typedef enum logic [FUNC_W-1:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,
        fn_shl = 6'd6,
        fn_shr = 6'd7
    } func_e;

    typedef enum logic [ALU_OP_W-1:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,  // unary ops work on operand b.
        alu_tcp,
        alu_shl,
        alu_shr
    } alu_op_e;

endpackage

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
    parameter int DMEM_DEPTH = 16
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              x_valid,
    input  wire cpu_pkg::word_t    x_pc,
    input  wire cpu_pkg::word_t    x_rs_data,
    input  wire cpu_pkg::word_t    x_rt_data,
    input  wire cpu_pkg::word_t    x_imm,
    input  wire cpu_pkg::reg_idx_t x_rs,
    input  wire cpu_pkg::reg_idx_t x_rt,
    input  wire cpu_pkg::reg_idx_t x_dest,
    input  wire cpu_pkg::alu_op_e  x_alu_op,
    input  wire logic              x_alu_src_imm,
    input  wire logic              x_mem_read,
    input  wire logic              x_mem_write,
    input  wire logic              x_reg_write,
    input  wire logic              w_we,
    input  wire cpu_pkg::reg_idx_t w_addr,
    input  wire cpu_pkg::word_t    w_data,
    output logic                   e_valid,
    output cpu_pkg::word_t         e_pc,
    output cpu_pkg::reg_idx_t      e_dest,
    output logic                   e_reg_write,
    output cpu_pkg::word_t         e_result
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    word_t             dmem [DMEM_DEPTH];
    word_t             op_a;
    word_t             fwd_b;
    word_t             op_b;
    word_t             alu_result;
    logic [ADDR_W-1:0] mem_addr;

    // previous instruction still sits in writeback.
    assign op_a  = (w_we && w_addr == x_rs) ? w_data : x_rs_data;
    assign fwd_b = (w_we && w_addr == x_rt) ? w_data : x_rt_data;
    assign op_b  = x_alu_src_imm ? x_imm : fwd_b;

    always_comb begin
        case (x_alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_not: alu_result = ~op_b;
            alu_tcp: alu_result = ~op_b + 1'b1;
            alu_shl: alu_result = op_b << 1;
            alu_shr: alu_result = op_b >> 1;  // logical.
            default: alu_result = '0;
        endcase
    end

    // address wraps at the memory size.
    assign mem_addr = alu_result[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (x_mem_write) begin
            dmem[mem_addr] <= fwd_b;  // store data comes from rt.
        end
    end

    assign e_valid     = x_valid;
    assign e_pc        = x_pc;
    assign e_dest      = x_dest;
    assign e_reg_write = x_reg_write;
    assign e_result    = x_mem_read ? dmem[mem_addr] : alu_result;

endmodule

`default_nettype wire

//--- id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              d_valid,
    input  wire cpu_pkg::word_t    d_pc,
    input  wire cpu_pkg::word_t    d_rs_data,
    input  wire cpu_pkg::word_t    d_rt_data,
    input  wire cpu_pkg::word_t    d_imm,
    input  wire cpu_pkg::reg_idx_t d_rs,
    input  wire cpu_pkg::reg_idx_t d_rt,
    input  wire cpu_pkg::reg_idx_t d_dest,
    input  wire cpu_pkg::alu_op_e  d_alu_op,
    input  wire logic              d_alu_src_imm,
    input  wire logic              d_mem_read,
    input  wire logic              d_mem_write,
    input  wire logic              d_reg_write,
    output logic                   x_valid,
    output cpu_pkg::word_t         x_pc,
    output cpu_pkg::word_t         x_rs_data,
    output cpu_pkg::word_t         x_rt_data,
    output cpu_pkg::word_t         x_imm,
    output cpu_pkg::reg_idx_t      x_rs,
    output cpu_pkg::reg_idx_t      x_rt,
    output cpu_pkg::reg_idx_t      x_dest,
    output cpu_pkg::alu_op_e       x_alu_op,
    output logic                   x_alu_src_imm,
    output logic                   x_mem_read,
    output logic                   x_mem_write,
    output logic                   x_reg_write
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            x_valid       <= 1'b0;
            x_pc          <= '0;
            x_rs_data     <= '0;
            x_rt_data     <= '0;
            x_imm         <= '0;
            x_rs          <= '0;
            x_rt          <= '0;
            x_dest        <= '0;
            x_alu_op      <= alu_add;
            x_alu_src_imm <= 1'b0;
            x_mem_read    <= 1'b0;
            x_mem_write   <= 1'b0;
            x_reg_write   <= 1'b0;
        end else begin
            x_valid       <= d_valid;
            x_pc          <= d_pc;
            x_rs_data     <= d_rs_data;
            x_rt_data     <= d_rt_data;
            x_imm         <= d_imm;
            x_rs          <= d_rs;
            x_rt          <= d_rt;
            x_dest        <= d_dest;
            x_alu_op      <= d_alu_op;
            x_alu_src_imm <= d_alu_src_imm;
            x_mem_read    <= d_valid & d_mem_read;  // bubbles carry no side effects.
            x_mem_write   <= d_valid & d_mem_write;
            x_reg_write   <= d_valid & d_reg_write;
        end
    end

endmodule

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              instr_valid,
    input  wire cpu_pkg::word_t    instr,
    input  wire logic              w_we,
    input  wire cpu_pkg::reg_idx_t w_addr,
    input  wire cpu_pkg::word_t    w_data,
    output logic                   d_valid,
    output cpu_pkg::word_t         d_pc,
    output cpu_pkg::word_t         d_rs_data,
    output cpu_pkg::word_t         d_rt_data,
    output cpu_pkg::word_t         d_imm,
    output cpu_pkg::reg_idx_t      d_rs,
    output cpu_pkg::reg_idx_t      d_rt,
    output cpu_pkg::reg_idx_t      d_dest,
    output cpu_pkg::alu_op_e       d_alu_op,
    output logic                   d_alu_src_imm,
    output logic                   d_mem_read,
    output logic                   d_mem_write,
    output logic                   d_reg_write
);
    import cpu_pkg::*;

    word_t    regs [NUM_REGS];
    word_t    pc_cnt;
    opcode_e  opcode;
    func_e    func;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t rd_idx;
    imm_t     imm8;
    word_t    imm_sext;
    word_t    imm_zext;

    assign opcode = opcode_e'(instr[OPC_LSB +: OPCODE_W]);
    assign func   = func_e'(instr[0 +: FUNC_W]);
    assign rs_idx = instr[RS_LSB +: REG_IDX_W];
    assign rt_idx = instr[RT_LSB +: REG_IDX_W];
    assign rd_idx = instr[RD_LSB +: REG_IDX_W];
    assign imm8   = instr[0 +: IMM_W];

    assign imm_sext = {{(WORD_W-IMM_W){imm8[IMM_W-1]}}, imm8};
    assign imm_zext = {{(WORD_W-IMM_W){1'b0}}, imm8};

    // counts accepted instructions only.
    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc_cnt <= '0;
        end else if (instr_valid) begin
            pc_cnt <= pc_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (w_we) begin
            regs[w_addr] <= w_data;
        end
    end

    // a write in this cycle wins over the stored word.
    assign d_rs_data = (w_we && w_addr == d_rs) ? w_data : regs[d_rs];
    assign d_rt_data = (w_we && w_addr == d_rt) ? w_data : regs[d_rt];

    assign d_valid = instr_valid;
    assign d_pc    = pc_cnt;

    always_comb begin
        d_rs          = rs_idx;
        d_rt          = rt_idx;
        d_dest        = rt_idx;  // i-type target.
        d_imm         = imm_sext;
        d_alu_op      = alu_add;
        d_alu_src_imm = 1'b0;
        d_mem_read    = 1'b0;
        d_mem_write   = 1'b0;
        d_reg_write   = 1'b0;
        case (opcode)
            op_rtype: begin
                d_dest      = rd_idx;
                d_reg_write = 1'b1;
                case (func)
                    fn_add:  d_alu_op = alu_add;
                    fn_sub:  d_alu_op = alu_sub;
                    fn_and:  d_alu_op = alu_and;
                    fn_orr:  d_alu_op = alu_or;
                    fn_not:  d_alu_op = alu_not;
                    fn_tcp:  d_alu_op = alu_tcp;
                    fn_shl:  d_alu_op = alu_shl;
                    fn_shr:  d_alu_op = alu_shr;
                    default: d_reg_write = 1'b0;
                endcase
                // unary ops read rs through the b lane.
                if (func inside {fn_not, fn_tcp, fn_shl, fn_shr}) begin
                    d_rt = rs_idx;
                end
            end
            op_adi: begin
                d_alu_src_imm = 1'b1;
                d_reg_write   = 1'b1;
            end
            op_ori: begin
                d_imm         = imm_zext;
                d_alu_op      = alu_or;
                d_alu_src_imm = 1'b1;
                d_reg_write   = 1'b1;
            end
            op_lhi: begin
                // shifter moves the byte into the high half.
                d_imm         = {1'b0, imm8, 7'b0};
                d_alu_op      = alu_shl;
                d_alu_src_imm = 1'b1;
                d_reg_write   = 1'b1;
            end
            op_lwd: begin
                d_alu_src_imm = 1'b1;
                d_mem_read    = 1'b1;
                d_reg_write   = 1'b1;
            end
            op_swd: begin
                d_alu_src_imm = 1'b1;
                d_mem_write   = 1'b1;
            end
            default: ;  // retires as a no-op.
        endcase
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cpu_pkg.sv
instr_decoder.sv
id_ex_reg.sv
execute_stage.sv
writeback_stage.sv
cpu_core.sv
tb_cpu.sv

//--- tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    word_t    pc;
    reg_idx_t dest;
    logic     we;
    word_t    data;
} expect_t;

// architectural state as the instruction set defines it.
word_t model_regs [NUM_REGS]  = '{default: '0};
word_t model_mem [DMEM_DEPTH] = '{default: '0};
word_t model_seq              = '0;

function automatic expect_t ref_execute(word_t ins);
    logic [3:0] opc;
    logic [5:0] fn;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      a;
    word_t      simm;
    word_t      addr_sum;
    expect_t    r;
    opc      = ins[15:12];
    fn       = ins[5:0];
    rs       = ins[11:10];
    rt       = ins[9:8];
    rd       = ins[7:6];
    a        = model_regs[rs];
    simm     = {{8{ins[7]}}, ins[7:0]};
    addr_sum = a + simm;
    r.pc     = model_seq;
    r.dest   = rt;
    r.we     = 1'b0;
    r.data   = '0;
    model_seq = model_seq + 1'b1;
    case (opc)
        op_rtype: begin
            r.dest = rd;
            r.we   = (fn < 6'd8);  // unknown functions write nothing.
            case (fn)
                fn_add:  r.data = a + model_regs[rt];
                fn_sub:  r.data = a - model_regs[rt];
                fn_and:  r.data = a & model_regs[rt];
                fn_orr:  r.data = a | model_regs[rt];
                fn_not:  r.data = ~a;
                fn_tcp:  r.data = -a;
                fn_shl:  r.data = a << 1;
                fn_shr:  r.data = a >> 1;
                default: ;
            endcase
        end
        op_adi: begin
            r.we   = 1'b1;
            r.data = a + simm;
        end
        op_ori: begin
            r.we   = 1'b1;
            r.data = a | {8'h00, ins[7:0]};
        end
        op_lhi: begin
            r.we   = 1'b1;
            r.data = {ins[7:0], 8'h00};
        end
        op_lwd: begin
            r.we   = 1'b1;
            r.data = model_mem[addr_sum % DMEM_DEPTH];
        end
        op_swd:  model_mem[addr_sum % DMEM_DEPTH] = model_regs[rt];
        default: ;
    endcase
    if (r.we) begin
        model_regs[r.dest] = r.data;
    end
    return r;
endfunction

`endif

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int DMEM_DEPTH = 16;
    localparam int WAIT_LIMIT = 60;

    logic     clk;
    logic     reset_n;
    logic     instr_valid;
    word_t    instr;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_dest;
    logic     retire_we;
    word_t    retire_data;
    integer   seed = 40;

    `include "tb_ref_model.svh"

    expect_t exp_q [$];
    expect_t head;

    cpu_core #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_dest  (retire_dest),
        .retire_we    (retire_we),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic word_t rtype_word(func_e fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t itype_word(opcode_e opc, reg_idx_t rs, reg_idx_t rt,
                                         logic [7:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'($random(seed));
    endfunction

    task automatic send_instr(word_t ins);
        exp_q.push_back(ref_execute(ins));
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= word_t'($random(seed));  // junk on a bubble.
    endtask

    // called right after the sampling edge, which counts as edge one.
    task automatic measure_latency();
        int   edges;
        logic seen;
        edges = 1;
        seen  = 1'b0;
        while (!seen && edges < WAIT_LIMIT) begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                edges++;
            end
        end
        if (!seen) begin
            $display("timeout: no retire arrived for the first instruction");
            abort_run();
        end else if (edges != 2) begin
            $display("first instruction retired %0d edges after sampling, not 2", edges);
            abort_run();
        end
    endtask

    task automatic drain_queue();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: no retire arrived for %0d instructions", exp_q.size());
        end
    endtask

    always @(negedge clk) begin
        if (reset_n === 1'b0 && retire_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("a retire arrived at %0t with no instruction outstanding", $time);
                abort_run();
            end else begin
                head = exp_q.pop_front();
                check_word("retire_pc", retire_pc, head.pc);
                check_reg("retire_dest", retire_dest, head.dest);
                check_bit("retire_we", retire_we, head.we);
                if (head.we) begin
                    check_word("retire_data", retire_data, head.data);
                end
            end
        end
    end

    initial begin
        int k;
        reset_n     = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b0;

        repeat (6) begin
            @(negedge clk);
            check_bit("retire_valid", retire_valid, 1'b0);
        end
        send_instr(itype_word(op_lhi, 2'd0, 2'd0, 8'h12));
        idle_cycle();
        measure_latency();

        // random register contents, then r-type over every function.
        for (int r = 0; r < NUM_REGS; r++) begin
            send_instr(itype_word(op_lhi, 2'd0, reg_idx_t'(r), 8'($random(seed))));
            send_instr(itype_word(op_ori, reg_idx_t'(r), reg_idx_t'(r), 8'($random(seed))));
        end
        for (int i = 0; i < 40; i++) begin
            send_instr(rtype_word(func_e'(6'(i % 8)), pick_reg(), pick_reg(),
                                  pick_reg()));
        end

        send_instr(itype_word(op_adi, 2'd1, 2'd2, 8'hF0));
        send_instr(itype_word(op_adi, 2'd2, 2'd3, 8'h80));  // most negative.
        send_instr(itype_word(op_adi, 2'd0, 2'd0, 8'hFF));
        send_instr(itype_word(op_ori, 2'd3, 2'd1, 8'h81));  // must not sign-extend.
        send_instr(itype_word(op_lhi, 2'd0, 2'd2, 8'hA5));
        for (int i = 0; i < 12; i++) begin
            k = $unsigned($random(seed)) % 3;
            send_instr(itype_word((k == 0) ? op_adi : (k == 1) ? op_ori : op_lhi,
                                  pick_reg(), pick_reg(), 8'($random(seed))));
        end

        // distance one through forwarding, distance two through the bypass.
        send_instr(itype_word(op_adi, 2'd0, 2'd1, 8'h05));
        send_instr(rtype_word(fn_add, 2'd2, 2'd1, 2'd1));
        send_instr(rtype_word(fn_sub, 2'd3, 2'd2, 2'd1));
        send_instr(itype_word(op_adi, 2'd3, 2'd3, 8'h01));
        send_instr(itype_word(op_adi, 2'd3, 2'd3, 8'h01));
        send_instr(itype_word(op_lhi, 2'd0, 2'd0, 8'h3C));
        send_instr(itype_word(op_ori, 2'd2, 2'd1, 8'h0F));
        send_instr(rtype_word(fn_and, 2'd1, 2'd0, 2'd3));
        send_instr(rtype_word(fn_tcp, 2'd2, 2'd1, 2'd0));
        send_instr(rtype_word(fn_orr, 2'd3, 2'd2, 2'd1));

        send_instr(itype_word(op_lhi, 2'd0, 2'd1, 8'h00));
        send_instr(itype_word(op_ori, 2'd1, 2'd1, 8'h0E));  // base 14.
        send_instr(itype_word(op_lhi, 2'd0, 2'd2, 8'hBE));
        send_instr(itype_word(op_swd, 2'd1, 2'd2, 8'h03));  // wraps to word 1.
        send_instr(itype_word(op_swd, 2'd1, 2'd1, 8'hF1));  // wraps to word 15.
        send_instr(itype_word(op_lwd, 2'd1, 2'd3, 8'h03));
        send_instr(itype_word(op_lwd, 2'd1, 2'd0, 8'hF1));
        for (int i = 0; i < 24; i++) begin
            send_instr(itype_word(($random(seed) & 1) ? op_swd : op_lwd, pick_reg(),
                                  pick_reg(), 8'($random(seed))));
        end

        // any opcode with bubbles in between.
        for (int i = 0; i < 60; i++) begin
            repeat ($unsigned($random(seed)) % 3) idle_cycle();
            send_instr(word_t'($random(seed)));
        end
        idle_cycle();
        drain_queue();
        repeat (5) @(negedge clk);

        if (exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "instructions never retired");
        end
    end

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              e_valid,
    input  wire cpu_pkg::word_t    e_pc,
    input  wire cpu_pkg::reg_idx_t e_dest,
    input  wire logic              e_reg_write,
    input  wire cpu_pkg::word_t    e_result,
    output logic                   w_we,
    output cpu_pkg::reg_idx_t      w_addr,
    output cpu_pkg::word_t         w_data,
    output logic                   retire_valid,
    output cpu_pkg::word_t         retire_pc,
    output cpu_pkg::reg_idx_t      retire_dest,
    output logic                   retire_we,
    output cpu_pkg::word_t         retire_data
);
    import cpu_pkg::*;

    logic     wb_valid;
    word_t    wb_pc;
    reg_idx_t wb_dest;
    logic     wb_we;
    word_t    wb_data;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_valid <= 1'b0;
            wb_pc    <= '0;
            wb_dest  <= '0;
            wb_we    <= 1'b0;
            wb_data  <= '0;
        end else begin
            wb_valid <= e_valid;
            wb_pc    <= e_pc;
            wb_dest  <= e_dest;
            wb_we    <= e_valid & e_reg_write;
            wb_data  <= e_result;
        end
    end

    // register file sees the same word that retires.
    assign w_we   = wb_we;
    assign w_addr = wb_dest;
    assign w_data = wb_data;

    assign retire_valid = wb_valid;
    assign retire_pc    = wb_pc;
    assign retire_dest  = wb_dest;
    assign retire_we    = wb_we;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire
